// File: hw/pin_ctrl_config.svh
`ifndef PIN_CTRL_CONFIG_SVH
`define PIN_CTRL_CONFIG_SVH

// number of pin controllers behind the bus.
`define PIN_COUNT 4

// wishbone data width, also the width of every pin register.
`define DATA_W 16

// word address width of the wishbone port.
`define ADDR_W 19

// width of the pin index field, address bits 15 to 8.
`define PIN_SEL_W 8

// width of the register offset field, address bits 7 to 0.
`define OFF_W 8

`endif

// File: hw/pin_ctrl_pkg.sv
`include "pin_ctrl_config.svh"

package pin_ctrl_pkg;

  // command codes, written to the global or the local command register.
  typedef enum logic [`DATA_W-1:0] {
    cmd_none         = 0,
    cmd_start_output = 1,
    cmd_input_stream = 3,
    cmd_stop         = 5,
    cmd_const_level  = 6
  } pin_cmd_e;

  // word offsets inside a pin's slot.
  typedef enum logic [`OFF_W-1:0] {
    off_global_cmd  = 0,
    off_duty        = 1,
    off_anti_duty   = 2,
    off_cycles      = 3,
    off_run_inf     = 4,
    off_local_cmd   = 5,
    off_sample_rate = 6,
    off_sample_reg  = 7,
    off_sample_cnt  = 8
  } reg_offset_e;

  // one decoded bus write, sent to every pin controller.
  typedef struct packed {
    logic                  strobe;
    logic                  broadcast;
    logic [`PIN_SEL_W-1:0] pin_sel;
    reg_offset_e           offset;
    logic [`DATA_W-1:0]    data;
  } reg_write_t;

  // settings of one pin.
  typedef struct packed {
    logic [`DATA_W-1:0] duty;
    logic [`DATA_W-1:0] anti_duty;
    logic [`DATA_W-1:0] cycles;
    logic               run_inf;
    logic [`DATA_W-1:0] sample_rate;
  } pin_cfg_t;

  // readable state of one pin.
  typedef struct packed {
    logic [`DATA_W-1:0] sample_reg;
    logic [`DATA_W-1:0] sample_cnt;
  } pin_status_t;

endpackage

// File: hw/wb_pin_bridge.sv
`timescale 1ns/1ns
`include "pin_ctrl_config.svh"

module wb_pin_bridge (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [`ADDR_W-1:0]        wb_adr,
  input  logic [`DATA_W-1:0]        wb_dat_w,
  output logic [`DATA_W-1:0]        wb_dat_r,
  output logic                      wb_ack,
  output pin_ctrl_pkg::reg_write_t  wr,
  output logic [`PIN_SEL_W-1:0]     rd_sel,
  output pin_ctrl_pkg::reg_offset_e rd_off,
  input  pin_ctrl_pkg::pin_status_t status [`PIN_COUNT]
);
  import pin_ctrl_pkg::*;

  logic               req;
  pin_status_t        sel_status;
  logic [`DATA_W-1:0] read_word;

  assign req    = wb_cyc & wb_stb;
  assign rd_sel = wb_adr[`OFF_W +: `PIN_SEL_W];
  assign rd_off = reg_offset_e'(wb_adr[`OFF_W-1:0]);

  // one wait cycle, then ack for exactly one cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req & ~wb_ack;
    end
  end

  // the write lands in the pin registers on the edge that ends the ack cycle.
  // offset 0 is the global command and goes to every pin.
  assign wr = '{
    strobe:    req & wb_we & wb_ack,
    broadcast: (rd_off == off_global_cmd),
    pin_sel:   rd_sel,
    offset:    rd_off,
    data:      wb_dat_w
  };

  always_comb begin
    sel_status = '0;
    for (int i = 0; i < `PIN_COUNT; i++) begin
      if (rd_sel == i) begin
        sel_status = status[i];
      end
    end
    case (rd_off)
      off_sample_reg: read_word = sel_status.sample_reg;
      off_sample_cnt: read_word = sel_status.sample_cnt;
      default:        read_word = '0;
    endcase
  end

  // read data is captured with ack, so it is stable through the ack cycle.
  always_ff @(posedge clk) begin
    if (req & ~wb_ack & ~wb_we) begin
      wb_dat_r <= read_word;
    end else begin
      wb_dat_r <= '0;
    end
  end

endmodule

// File: hw/pin_reg_bank.sv
`timescale 1ns/1ns

module pin_reg_bank #(
  parameter int POSITION = 0
) (
  input  logic                     clk,
  input  logic                     reset,
  input  pin_ctrl_pkg::reg_write_t wr,
  input  logic                     take,
  output pin_ctrl_pkg::pin_cfg_t   cfg,
  output pin_ctrl_pkg::pin_cmd_e   command
);
  import pin_ctrl_pkg::*;

  logic accept;

  // broadcast writes ignore the pin index.
  assign accept = wr.strobe & (wr.broadcast | (wr.pin_sel == POSITION));

  always_ff @(posedge clk) begin
    if (reset) begin
      command <= cmd_none;
      cfg     <= '0;
    end else begin
      // commands are single shot, cleared once the sequencer takes them.
      if (take) begin
        command <= cmd_none;
      end
      // a new command written in the take cycle wins over the clear.
      if (accept) begin
        case (wr.offset)
          off_global_cmd: begin
            command <= pin_cmd_e'(wr.data);
          end
          off_local_cmd: begin
            command <= pin_cmd_e'(wr.data);
          end
          off_duty: begin
            cfg.duty <= wr.data;
          end
          off_anti_duty: begin
            cfg.anti_duty <= wr.data;
          end
          off_cycles: begin
            cfg.cycles <= wr.data;
          end
          off_run_inf: begin
            cfg.run_inf <= wr.data[0];
          end
          off_sample_rate: begin
            cfg.sample_rate <= wr.data;
          end
          default: begin
            // sample registers are read only.
          end
        endcase
      end
    end
  end

endmodule

// File: hw/pin_sequencer.sv
`timescale 1ns/1ns
`include "pin_ctrl_config.svh"

module pin_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  pin_ctrl_pkg::pin_cfg_t    cfg,
  input  pin_ctrl_pkg::pin_cmd_e    command,
  output logic                      take,
  input  logic                      pin_in,
  output logic                      pin_out,
  output logic                      pin_oe,
  output pin_ctrl_pkg::pin_status_t status
);
  import pin_ctrl_pkg::*;

  typedef enum logic [4:0] {
    st_idle         = 5'b00001,
    st_high         = 5'b00010,
    st_low          = 5'b00100,
    st_input_stream = 5'b01000,
    st_const_level  = 5'b10000
  } state_e;

  state_e             state;
  state_e             next_state;
  logic [`DATA_W-1:0] cnt_duty;
  logic [`DATA_W-1:0] cnt_anti;
  logic [`DATA_W-1:0] cnt_cycles;
  logic [`DATA_W-1:0] cnt_sample;
  logic [`DATA_W-1:0] sample_reg;
  logic [`DATA_W-1:0] sample_cnt;
  logic               res_duty;
  logic               dec_duty;
  logic               res_anti;
  logic               dec_anti;
  logic               res_cycles;
  logic               dec_cycles;
  logic               res_sample;
  logic               dec_sample;
  logic               do_sample;
  logic               stop_req;

  assign stop_req = (command == cmd_stop);

  always_comb begin
    next_state = state;
    take       = 1'b0;
    res_duty   = 1'b0;
    dec_duty   = 1'b0;
    res_anti   = 1'b0;
    dec_anti   = 1'b0;
    res_cycles = 1'b0;
    dec_cycles = 1'b0;
    res_sample = 1'b0;
    dec_sample = 1'b0;
    do_sample  = 1'b0;
    case (state)
      st_idle: begin
        // keep every counter loaded so a new command starts clean.
        res_duty   = 1'b1;
        res_anti   = 1'b1;
        res_cycles = 1'b1;
        res_sample = 1'b1;
        case (command)
          cmd_start_output: next_state = st_high;
          cmd_input_stream: next_state = st_input_stream;
          cmd_const_level:  next_state = st_const_level;
          default:          next_state = st_idle;
        endcase
        take = (next_state != st_idle) | stop_req;
      end
      st_high: begin
        dec_duty = 1'b1;
        if (stop_req) begin
          next_state = st_idle;
          take       = 1'b1;
        end else if (cnt_duty <= 1) begin
          res_duty   = 1'b1;
          next_state = st_low;
        end
      end
      st_low: begin
        dec_anti = 1'b1;
        if (stop_req) begin
          next_state = st_idle;
          take       = 1'b1;
        end else if (cnt_anti <= 1) begin
          // end of one period.
          res_anti   = 1'b1;
          dec_cycles = 1'b1;
          if (!cfg.run_inf && (cnt_cycles <= 1)) begin
            next_state = st_idle;
          end else begin
            next_state = st_high;
          end
        end
      end
      st_input_stream: begin
        if (cnt_sample <= 1) begin
          do_sample  = 1'b1;
          res_sample = 1'b1;
        end else begin
          dec_sample = 1'b1;
        end
        if (stop_req) begin
          next_state = st_idle;
          take       = 1'b1;
        end
      end
      st_const_level: begin
        if (stop_req) begin
          next_state = st_idle;
          take       = 1'b1;
        end
      end
      default: begin
        next_state = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  // down counters, reload has priority over decrement.
  always_ff @(posedge clk) begin
    if (res_duty) begin
      cnt_duty <= cfg.duty;
    end else if (dec_duty) begin
      cnt_duty <= cnt_duty - 1'b1;
    end
    if (res_anti) begin
      cnt_anti <= cfg.anti_duty;
    end else if (dec_anti) begin
      cnt_anti <= cnt_anti - 1'b1;
    end
    if (res_cycles) begin
      cnt_cycles <= cfg.cycles;
    end else if (dec_cycles) begin
      cnt_cycles <= cnt_cycles - 1'b1;
    end
    if (res_sample) begin
      cnt_sample <= cfg.sample_rate;
    end else if (dec_sample) begin
      cnt_sample <= cnt_sample - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_reg <= '0;
      sample_cnt <= '0;
    end else if (do_sample) begin
      sample_reg <= {sample_reg[`DATA_W-2:0], pin_in};
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  assign status = '{sample_reg: sample_reg, sample_cnt: sample_cnt};

  // pad controls follow the state one cycle later, from flops only.
  always_ff @(posedge clk) begin
    if (reset) begin
      pin_oe  <= 1'b0;
      pin_out <= 1'b0;
    end else begin
      pin_oe  <= (state == st_high) | (state == st_low) | (state == st_const_level);
      pin_out <= (state == st_high) | ((state == st_const_level) & (cfg.duty != 0));
    end
  end

endmodule

// File: hw/pin_controller.sv
`timescale 1ns/1ns

module pin_controller #(
  parameter int POSITION = 0
) (
  input  logic                      clk,
  input  logic                      reset,
  input  pin_ctrl_pkg::reg_write_t  wr,
  output pin_ctrl_pkg::pin_status_t status,
  inout  wire                       pin
);
  import pin_ctrl_pkg::*;

  pin_cfg_t cfg;
  pin_cmd_e command;
  logic     take;
  logic     pin_out;
  logic     pin_oe;

  pin_reg_bank #(
    .POSITION (POSITION)
  ) u_reg_bank (
    .clk     (clk),
    .reset   (reset),
    .wr      (wr),
    .take    (take),
    .cfg     (cfg),
    .command (command)
  );

  pin_sequencer u_sequencer (
    .clk     (clk),
    .reset   (reset),
    .cfg     (cfg),
    .command (command),
    .take    (take),
    .pin_in  (pin),
    .pin_out (pin_out),
    .pin_oe  (pin_oe),
    .status  (status)
  );

  // driver off means the pad is an input.
  assign pin = pin_oe ? pin_out : 1'bz;

endmodule

// File: hw/pin_array_top.sv
`timescale 1ns/1ns
`include "pin_ctrl_config.svh"

module pin_array_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`ADDR_W-1:0]    wb_adr,
  input  logic [`DATA_W-1:0]    wb_dat_w,
  output logic [`DATA_W-1:0]    wb_dat_r,
  output logic                  wb_ack,
  inout  wire  [`PIN_COUNT-1:0] pins
);
  import pin_ctrl_pkg::*;

  reg_write_t  wr;
  pin_status_t status [`PIN_COUNT];

  wb_pin_bridge u_bridge (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .wr       (wr),
    .rd_sel   (),
    .rd_off   (),
    .status   (status)
  );

  // one controller per pin, each owning its own slot of the address map.
  for (genvar i = 0; i < `PIN_COUNT; i++) begin : g_pin
    pin_controller #(
      .POSITION (i)
    ) u_pin (
      .clk    (clk),
      .reset  (reset),
      .wr     (wr),
      .status (status[i]),
      .pin    (pins[i])
    );
  end

endmodule

// File: verif/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
  output logic clk,
  output logic reset
);

  // 20 ns period.
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset held for five rising edges, released on a falling edge.
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// File: verif/pin_array_tb.sv
`timescale 1ns/1ns
`include "pin_ctrl_config.svh"

module pin_array_tb;
  import pin_ctrl_pkg::*;

  localparam int N_TESTS = 8;

  logic                  clk;
  logic                  reset;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`ADDR_W-1:0]    wb_adr;
  logic [`DATA_W-1:0]    wb_dat_w;
  logic [`DATA_W-1:0]    wb_dat_r;
  logic                  wb_ack;
  wire  [`PIN_COUNT-1:0] pins;
  logic [`PIN_COUNT-1:0] drv_en;
  logic [`PIN_COUNT-1:0] drv_level;

  // test table, one column per array.
  // pin -1 means a global command, level is the level held on the pin in input tests.
  string names [N_TESTS];
  int    t_pin [N_TESTS];
  int    t_cmd [N_TESTS];
  int    t_duty [N_TESTS];
  int    t_anti [N_TESTS];
  int    t_cycles [N_TESTS];
  int    t_inf [N_TESTS];
  int    t_rate [N_TESTS];
  int    t_level [N_TESTS];
  int    t_window [N_TESTS];
  // per-pin settings used by the global entry.
  int    g_duty [`PIN_COUNT];
  int    g_anti [`PIN_COUNT];
  int    g_cycles [`PIN_COUNT];
  int    n_tests = 0;
  int    limit = 0;
  int    cycle_count = 0;
  logic [31:0] lfsr = 32'h5ae9518d;

  clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  pin_array_top uut (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .pins     (pins)
  );

  // testbench drivers, only enabled while the DUT driver is off.
  for (genvar p = 0; p < `PIN_COUNT; p++) begin : g_drive
    assign pins[p] = drv_en[p] ? drv_level[p] : 1'bz;
  end

  always @(posedge clk) begin
    if (!reset) begin
      cycle_count++;
    end
    if ((limit > 0) && (cycle_count > limit)) begin
      $display("run did not finish within %0d cycles", limit);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // three bits, one LFSR step each.
  task automatic rand_1_to_8(output int v);
    v = 0;
    repeat (3) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | lfsr[0];
    end
    v = v + 1;
  endtask

  function automatic int at_least_one(input int v);
    return (v > 1) ? v : 1;
  endfunction

  task automatic add_entry(input string name, input int pin, input int cmd, input int duty,
                           input int anti, input int cycles, input int inf, input int rate,
                           input int level, input int window);
    names[n_tests]    = name;
    t_pin[n_tests]    = pin;
    t_cmd[n_tests]    = cmd;
    t_duty[n_tests]   = duty;
    t_anti[n_tests]   = anti;
    t_cycles[n_tests] = cycles;
    t_inf[n_tests]    = inf;
    t_rate[n_tests]   = rate;
    t_level[n_tests]  = level;
    t_window[n_tests] = window;
    // bus traffic costs well under 40 cycles per pin touched.
    limit   = limit + window + 40 * ((pin < 0) ? `PIN_COUNT : 1);
    n_tests = n_tests + 1;
  endtask

  // level expected on pin p at the k-th falling edge after the command write.
  function automatic logic expected_level(input int i, input int p, input int k);
    int cmd;
    int d;
    int a;
    int c;
    int raw_duty;
    int t;
    cmd      = ((t_pin[i] < 0) || (t_pin[i] == p)) ? t_cmd[i] : cmd_none;
    raw_duty = (t_pin[i] < 0) ? g_duty[p] : t_duty[i];
    d        = at_least_one(raw_duty);
    a        = at_least_one((t_pin[i] < 0) ? g_anti[p] : t_anti[i]);
    c        = at_least_one((t_pin[i] < 0) ? g_cycles[p] : t_cycles[i]);
    t        = k - 2;
    if ((cmd == cmd_none) || (cmd == cmd_input_stream) || (t < 0)) begin
      return 1'bz;
    end
    if (cmd == cmd_const_level) begin
      return (raw_duty != 0);
    end
    if ((t_inf[i] == 0) && (t >= c * (d + a))) begin
      return 1'bz;
    end
    return ((t % (d + a)) < d);
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s expected %0h actual %0h", what, expected, actual);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  // one classic cycle, called and left on a falling edge.
  task automatic bus_access(input logic we, input int pin, input reg_offset_e off,
                            input logic [`DATA_W-1:0] data,
                            output logic [`DATA_W-1:0] rdata);
    int waits;
    wb_adr                         = '0;
    wb_adr[`OFF_W +: `PIN_SEL_W]   = pin;
    wb_adr[`OFF_W-1:0]             = off;
    wb_dat_w                       = data;
    wb_we                          = we;
    wb_cyc                         = 1'b1;
    wb_stb                         = 1'b1;
    waits                          = 0;
    do begin
      @(negedge clk);
      waits++;
    end while (!wb_ack);
    rdata = wb_dat_r;
    assert (waits == 1) else begin
      $display("wishbone ack came %0d cycles after stb instead of one", waits);
      $display("** FAIL **");
      $fatal(1, "bus handshake");
    end
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    assert (!wb_ack) else begin
      $display("wishbone ack stayed high for more than one cycle");
      $display("** FAIL **");
      $fatal(1, "bus handshake");
    end
  endtask

  task automatic write_reg(input int pin, input reg_offset_e off, input int data);
    logic [`DATA_W-1:0] unused;
    bus_access(1'b1, pin, off, data, unused);
  endtask

  task automatic read_reg(input int pin, input reg_offset_e off,
                          output logic [`DATA_W-1:0] data);
    bus_access(1'b0, pin, off, '0, data);
  endtask

  task automatic configure_pin(input int p, input int duty, input int anti, input int cycles,
                               input int inf, input int rate);
    write_reg(p, off_duty, duty);
    write_reg(p, off_anti_duty, anti);
    write_reg(p, off_cycles, cycles);
    write_reg(p, off_run_inf, inf);
    write_reg(p, off_sample_rate, rate);
  endtask

  task automatic monitor_pins(input int i);
    for (int k = 1; k <= t_window[i]; k++) begin
      @(negedge clk);
      for (int p = 0; p < `PIN_COUNT; p++) begin
        check_value($sformatf("%s pin %0d cycle %0d", names[i], p, k),
                    {31'b0, expected_level(i, p, k)}, {31'b0, pins[p]});
      end
    end
  endtask

  // the driver must be off by the second falling edge after the write.
  task automatic stop_and_check(input int i, input int p);
    write_reg(p, off_local_cmd, cmd_stop);
    for (int k = 1; k <= 5; k++) begin
      @(negedge clk);
      if (k >= 2) begin
        check_value($sformatf("%s stop pin %0d cycle %0d", names[i], p, k),
                    {31'b0, 1'bz}, {31'b0, pins[p]});
      end
    end
  endtask

  task automatic run_entry(input int i);
    int p;
    int expected;
    logic [`DATA_W-1:0] cnt0;
    logic [`DATA_W-1:0] cnt1;
    logic [`DATA_W-1:0] sreg;
    logic [`DATA_W-1:0] diff;
    p = t_pin[i];
    if (t_cmd[i] == cmd_none) begin
      monitor_pins(i);
      for (int q = 0; q < `PIN_COUNT; q++) begin
        read_reg(q, off_sample_cnt, cnt0);
        check_value($sformatf("%s sample_cnt pin %0d", names[i], q), 0, cnt0);
      end
    end else if (t_cmd[i] == cmd_input_stream) begin
      configure_pin(p, 0, 0, 0, 0, t_rate[i]);
      drv_level[p] = t_level[i];
      drv_en[p]    = 1'b1;
      read_reg(p, off_sample_cnt, cnt0);
      write_reg(p, off_local_cmd, cmd_input_stream);
      repeat (t_window[i]) @(negedge clk);
      read_reg(p, off_sample_cnt, cnt1);
      read_reg(p, off_sample_reg, sreg);
      write_reg(p, off_local_cmd, cmd_stop);
      drv_en[p] = 1'b0;
      diff      = cnt1 - cnt0;
      expected  = t_window[i] / at_least_one(t_rate[i]);
      assert ((diff + 1 >= expected) && (diff <= expected + 1)) else begin
        $display("FAILED %s expected %0d +-1 actual %0d", names[i], expected, diff);
        $display("** FAIL **");
        $fatal(1, "sample count");
      end
      check_value({names[i], " sample_reg bit 0"}, t_level[i], sreg[0]);
    end else if (p < 0) begin
      for (int q = 0; q < `PIN_COUNT; q++) begin
        configure_pin(q, g_duty[q], g_anti[q], g_cycles[q], 0, 0);
      end
      // the pin index of a global command is ignored.
      write_reg(2, off_global_cmd, t_cmd[i]);
      monitor_pins(i);
    end else begin
      configure_pin(p, t_duty[i], t_anti[i], t_cycles[i], t_inf[i], 0);
      write_reg(p, off_local_cmd, t_cmd[i]);
      monitor_pins(i);
      if ((t_inf[i] != 0) || (t_cmd[i] == cmd_const_level)) begin
        stop_and_check(i, p);
      end
    end
  endtask

  initial begin
    int d;
    int a;
    int c;
    int w;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    drv_en    = '0;
    drv_level = '0;

    add_entry("reset_idle", 0, cmd_none, 0, 0, 0, 0, 0, 0, 10);
    rand_1_to_8(d);
    rand_1_to_8(a);
    rand_1_to_8(c);
    add_entry("finite_train", 1, cmd_start_output, d, a, c, 0, 0, 0, 1 + c * (d + a) + 4);
    rand_1_to_8(d);
    rand_1_to_8(a);
    // endless train runs well past its two periods.
    add_entry("endless_train", 2, cmd_start_output, d, a, 2, 1, 0, 0, 1 + 4 * (d + a) + 3);
    add_entry("const_high", 3, cmd_const_level, 5, 0, 0, 0, 0, 0, 20);
    add_entry("const_low", 0, cmd_const_level, 0, 0, 0, 0, 0, 0, 20);
    add_entry("stream_high", 1, cmd_input_stream, 0, 0, 0, 0, 3, 1, 40);
    add_entry("stream_low", 2, cmd_input_stream, 0, 0, 0, 0, 0, 0, 30);
    w = 0;
    for (int p = 0; p < `PIN_COUNT; p++) begin
      rand_1_to_8(g_duty[p]);
      rand_1_to_8(g_anti[p]);
      rand_1_to_8(g_cycles[p]);
      if (g_cycles[p] * (g_duty[p] + g_anti[p]) > w) begin
        w = g_cycles[p] * (g_duty[p] + g_anti[p]);
      end
    end
    add_entry("global_train", -1, cmd_start_output, 0, 0, 0, 0, 0, 0, 1 + w + 4);
    limit = limit + 200;

    wait (reset === 1'b0);
    @(negedge clk);
    for (int i = 0; i < n_tests; i++) begin
      run_entry(i);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// File: tb.f
+incdir+hw
hw/pin_ctrl_pkg.sv
hw/wb_pin_bridge.sv
hw/pin_reg_bank.sv
hw/pin_sequencer.sv
hw/pin_controller.sv
hw/pin_array_top.sv
verif/clock_gen.sv
verif/pin_array_tb.sv

// File: Bender.yml
package:
  name: pin_array

sources:
  - include_dirs:
      - hw
    files:
      - hw/pin_ctrl_pkg.sv
      - hw/wb_pin_bridge.sv
      - hw/pin_reg_bank.sv
      - hw/pin_sequencer.sv
      - hw/pin_controller.sv
      - hw/pin_array_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/clock_gen.sv
      - verif/pin_array_tb.sv
